//--- hdl/exu_defines.svh
// execution stage widths and machine-mode CSR addresses
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// datapath
`define EXU_XLEN         32
`define EXU_REG_ADDR_W   5
`define EXU_COMMIT_ID_W  3

// CSR address space
`define EXU_CSR_ADDR_W   12

// machine-mode CSRs that are implemented
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MSCRATCH 12'h340
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

`endif

//--- hdl/exu_pkg.sv
// execution stage types for operation encodings, unit requests and write-back records
`include "exu_defines.svh"

package exu_pkg;

    // RV32I integer operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // jumps and conditional branches
    typedef enum logic [2:0] {
        bru_jal  = 3'd0,
        bru_jalr = 3'd1,
        bru_beq  = 3'd2,
        bru_bne  = 3'd3,
        bru_blt  = 3'd4,
        bru_bltu = 3'd5,
        bru_bge  = 3'd6,
        bru_bgeu = 3'd7
    } bru_op_e;

    // csrrw, csrrs, csrrc
    typedef enum logic [1:0] {
        csr_rw = 2'd0,
        csr_rs = 2'd1,
        csr_rc = 2'd2
    } csr_op_e;

    typedef struct packed {
        alu_op_e                     op;
        logic [`EXU_XLEN-1:0]        op1;
        logic [`EXU_XLEN-1:0]        op2;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic                        reg_we;
        logic [`EXU_COMMIT_ID_W-1:0] commit_id;
    } alu_req_t;

    // op1/op2 feed the compare, jump_op1/jump_op2 form the target
    typedef struct packed {
        bru_op_e              op;
        logic [`EXU_XLEN-1:0] op1;
        logic [`EXU_XLEN-1:0] op2;
        logic [`EXU_XLEN-1:0] jump_op1;
        logic [`EXU_XLEN-1:0] jump_op2;
    } bru_req_t;

    typedef struct packed {
        csr_op_e                     op;
        logic [`EXU_CSR_ADDR_W-1:0]  addr;
        logic [`EXU_XLEN-1:0]        operand;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        logic                        csr_we;
        logic                        reg_we;
        logic [`EXU_COMMIT_ID_W-1:0] commit_id;
    } csr_req_t;

    // register file write-back port
    typedef struct packed {
        logic [`EXU_XLEN-1:0]        wdata;
        logic [`EXU_REG_ADDR_W-1:0]  waddr;
        logic                        we;
        logic [`EXU_COMMIT_ID_W-1:0] commit_id;
    } wb_t;

endpackage

//--- hdl/exu_alu.sv
// integer ALU with a one-cycle registered write-back that holds under back-pressure
`include "exu_defines.svh"

module exu_alu import exu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     flush_i,
    input  logic     req_i,
    input  alu_req_t req_data_i,
    input  logic     wb_ready_i,
    output wb_t      wb_o,
    output logic     stall_o
);

    logic [`EXU_XLEN-1:0] result;
    logic [4:0]           shamt;
    logic                 accept;
    logic                 valid_q;
    wb_t                  wb_q;

    assign shamt = req_data_i.op2[4:0];

    always_comb begin
        case (req_data_i.op)
            alu_add:  result = req_data_i.op1 + req_data_i.op2;
            alu_sub:  result = req_data_i.op1 - req_data_i.op2;
            alu_sll:  result = req_data_i.op1 << shamt;
            alu_slt:  result = {{(`EXU_XLEN-1){1'b0}},
                                $signed(req_data_i.op1) < $signed(req_data_i.op2)};
            alu_sltu: result = {{(`EXU_XLEN-1){1'b0}}, req_data_i.op1 < req_data_i.op2};
            alu_xor:  result = req_data_i.op1 ^ req_data_i.op2;
            alu_srl:  result = req_data_i.op1 >> shamt;
            alu_sra:  result = $signed(req_data_i.op1) >>> shamt;
            alu_or:   result = req_data_i.op1 | req_data_i.op2;
            alu_and:  result = req_data_i.op1 & req_data_i.op2;
            default:  result = '0;
        endcase
    end

    // held result blocks new work until write-back takes it
    assign stall_o = valid_q & ~wb_ready_i;
    assign accept  = req_i & ~flush_i & ~stall_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_q.wdata     <= result;
            wb_q.waddr     <= req_data_i.rd;
            wb_q.we        <= req_data_i.reg_we;
            wb_q.commit_id <= req_data_i.commit_id;
        end
    end

    // we only counts while the slot holds a live result
    always_comb begin
        wb_o    = wb_q;
        wb_o.we = wb_q.we & valid_q;
    end

    // dispatch must hold off while the write-back slot is blocked
    no_req_during_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i) stall_o |-> !req_i
    );

endmodule

//--- hdl/exu_bru.sv
// branch unit that resolves branches and merges interrupt and mret redirects
`include "exu_defines.svh"

module exu_bru import exu_pkg::*; (
    input  logic                 req_i,
    input  bru_req_t             req_data_i,
    input  logic                 int_jump_i,
    input  logic [`EXU_XLEN-1:0] int_addr_i,
    input  logic                 mret_i,
    input  logic [`EXU_XLEN-1:0] mepc_i,
    output logic                 jump_flag_o,
    output logic [`EXU_XLEN-1:0] jump_addr_o,
    output logic                 misaligned_fetch_o
);

    logic                 cond;
    logic                 taken;
    logic                 branch_sel;
    logic [`EXU_XLEN-1:0] target;

    always_comb begin
        case (req_data_i.op)
            bru_jal,
            bru_jalr: cond = 1'b1;
            bru_beq:  cond = req_data_i.op1 == req_data_i.op2;
            bru_bne:  cond = req_data_i.op1 != req_data_i.op2;
            bru_blt:  cond = $signed(req_data_i.op1) < $signed(req_data_i.op2);
            bru_bltu: cond = req_data_i.op1 < req_data_i.op2;
            bru_bge:  cond = $signed(req_data_i.op1) >= $signed(req_data_i.op2);
            bru_bgeu: cond = req_data_i.op1 >= req_data_i.op2;
            default:  cond = 1'b0;
        endcase
    end

    assign taken = req_i & cond;

    always_comb begin
        target = req_data_i.jump_op1 + req_data_i.jump_op2;
        // jalr drops the low bit of the sum
        if (req_data_i.op == bru_jalr) begin
            target[0] = 1'b0;
        end
    end

    // interrupt beats mret, mret beats the branch
    assign branch_sel  = taken & ~int_jump_i & ~mret_i;
    assign jump_flag_o = int_jump_i | mret_i | taken;

    always_comb begin
        if (int_jump_i) begin
            jump_addr_o = int_addr_i;
        end else if (mret_i) begin
            jump_addr_o = mepc_i;
        end else begin
            jump_addr_o = target;
        end
    end

    assign misaligned_fetch_o = branch_sel & target[1];

endmodule

//--- hdl/exu_csr_unit.sv
// CSR unit for read-modify-write execution with a registered write-back of the old value
`include "exu_defines.svh"

module exu_csr_unit import exu_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       req_i,
    input  csr_req_t                   req_data_i,
    input  logic                       wb_ready_i,
    output logic [`EXU_CSR_ADDR_W-1:0] csr_raddr_o,
    input  logic [`EXU_XLEN-1:0]       csr_rdata_i,
    output logic                       csr_we_o,
    output logic [`EXU_XLEN-1:0]       csr_wdata_o,
    output wb_t                        wb_o,
    output logic                       stall_o
);

    logic accept;
    logic valid_q;
    wb_t  wb_q;

    assign stall_o = valid_q & ~wb_ready_i;
    assign accept  = req_i & ~flush_i & ~stall_o;

    // the file reads this address combinationally and writes it at the same edge
    assign csr_raddr_o = req_data_i.addr;

    always_comb begin
        case (req_data_i.op)
            csr_rw:  csr_wdata_o = req_data_i.operand;
            csr_rs:  csr_wdata_o = csr_rdata_i | req_data_i.operand;
            csr_rc:  csr_wdata_o = csr_rdata_i & ~req_data_i.operand;
            default: csr_wdata_o = csr_rdata_i;
        endcase
    end

    assign csr_we_o = accept & req_data_i.csr_we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // rd gets the value from before the update
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_q.wdata     <= csr_rdata_i;
            wb_q.waddr     <= req_data_i.rd;
            wb_q.we        <= req_data_i.reg_we;
            wb_q.commit_id <= req_data_i.commit_id;
        end
    end

    always_comb begin
        wb_o    = wb_q;
        wb_o.we = wb_q.we & valid_q;
    end

    no_req_during_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i) stall_o |-> !req_i
    );

endmodule

//--- hdl/exu_csr_file.sv
// machine-mode CSR registers with a combinational read and a clocked write
`include "exu_defines.svh"

module exu_csr_file (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [`EXU_CSR_ADDR_W-1:0] raddr_i,
    output logic [`EXU_XLEN-1:0]       rdata_o,
    input  logic                       we_i,
    input  logic [`EXU_XLEN-1:0]       wdata_i,
    output logic [`EXU_XLEN-1:0]       mepc_o
);

    logic [`EXU_XLEN-1:0] mstatus_q;
    logic [`EXU_XLEN-1:0] mtvec_q;
    logic [`EXU_XLEN-1:0] mscratch_q;
    logic [`EXU_XLEN-1:0] mepc_q;
    logic [`EXU_XLEN-1:0] mcause_q;

    // unimplemented addresses read as zero
    always_comb begin
        case (raddr_i)
            `EXU_CSR_MSTATUS:  rdata_o = mstatus_q;
            `EXU_CSR_MTVEC:    rdata_o = mtvec_q;
            `EXU_CSR_MSCRATCH: rdata_o = mscratch_q;
            `EXU_CSR_MEPC:     rdata_o = mepc_q;
            `EXU_CSR_MCAUSE:   rdata_o = mcause_q;
            default:           rdata_o = '0;
        endcase
    end

    // write address is the read address of the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (we_i) begin
            case (raddr_i)
                `EXU_CSR_MSTATUS:  mstatus_q  <= wdata_i;
                `EXU_CSR_MTVEC:    mtvec_q    <= wdata_i;
                `EXU_CSR_MSCRATCH: mscratch_q <= wdata_i;
                `EXU_CSR_MEPC:     mepc_q     <= wdata_i;
                `EXU_CSR_MCAUSE:   mcause_q   <= wdata_i;
                default: ;
            endcase
        end
    end

    // return target for mret
    assign mepc_o = mepc_q;

endmodule

//--- hdl/exu.sv
// execution stage top that connects the ALU, branch unit, CSR unit and CSR file
`include "exu_defines.svh"

module exu import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 req_alu_i,
    input  alu_req_t             req_alu_data_i,
    input  logic                 alu_wb_ready_i,
    input  logic                 req_bjp_i,
    input  bru_req_t             req_bjp_data_i,
    input  logic                 int_jump_i,
    input  logic [`EXU_XLEN-1:0] int_addr_i,
    input  logic                 mret_i,
    input  logic                 req_csr_i,
    input  csr_req_t             req_csr_data_i,
    input  logic                 csr_wb_ready_i,
    output wb_t                  alu_wb_o,
    output logic                 alu_stall_o,
    output wb_t                  csr_wb_o,
    output logic                 csr_stall_o,
    output logic                 jump_flag_o,
    output logic [`EXU_XLEN-1:0] jump_addr_o,
    output logic                 misaligned_fetch_o
);

    logic [`EXU_CSR_ADDR_W-1:0] csr_raddr;
    logic [`EXU_XLEN-1:0]       csr_rdata;
    logic                       csr_we;
    logic [`EXU_XLEN-1:0]       csr_wdata;
    logic [`EXU_XLEN-1:0]       mepc;

    exu_alu u_alu (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .req_i      (req_alu_i),
        .req_data_i (req_alu_data_i),
        .wb_ready_i (alu_wb_ready_i),
        .wb_o       (alu_wb_o),
        .stall_o    (alu_stall_o)
    );

    exu_bru u_bru (
        .req_i              (req_bjp_i),
        .req_data_i         (req_bjp_data_i),
        .int_jump_i         (int_jump_i),
        .int_addr_i         (int_addr_i),
        .mret_i             (mret_i),
        .mepc_i             (mepc),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o),
        .misaligned_fetch_o (misaligned_fetch_o)
    );

    exu_csr_unit u_csr_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .req_i       (req_csr_i),
        .req_data_i  (req_csr_data_i),
        .wb_ready_i  (csr_wb_ready_i),
        .csr_raddr_o (csr_raddr),
        .csr_rdata_i (csr_rdata),
        .csr_we_o    (csr_we),
        .csr_wdata_o (csr_wdata),
        .wb_o        (csr_wb_o),
        .stall_o     (csr_stall_o)
    );

    exu_csr_file u_csr_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .we_i    (csr_we),
        .wdata_i (csr_wdata),
        .mepc_o  (mepc)
    );

endmodule

//--- testbench/tb_clock.sv
// clock and reset source for the execution stage testbench
module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    // period of 4
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held for the first 4 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- testbench/tb_exu.sv
// testbench for the execution stage with reference models and a cycle-by-cycle compare
`include "exu_defines.svh"

module tb_exu import exu_pkg::*; ();

    localparam int n_alu     = 64;
    localparam int n_bru     = 64;
    localparam int num_tests = n_alu + n_bru + 24;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 req_alu;
    alu_req_t             alu_data;
    logic                 alu_ready;
    logic                 req_bjp;
    bru_req_t             bjp_data;
    logic                 int_jump;
    logic [`EXU_XLEN-1:0] int_addr;
    logic                 mret;
    logic                 req_csr;
    csr_req_t             csr_data;
    logic                 csr_ready;
    wb_t                  alu_wb;
    wb_t                  csr_wb;
    logic                 alu_stall;
    logic                 csr_stall;
    logic                 jump_flag;
    logic [`EXU_XLEN-1:0] jump_addr;
    logic                 misaligned;

    // expected state of both write-back slots and the CSRs
    logic                 alu_valid;
    logic                 csr_valid;
    wb_t                  alu_exp;
    wb_t                  csr_exp;
    logic [`EXU_XLEN-1:0] csr_model [logic [`EXU_CSR_ADDR_W-1:0]];
    logic [15:0]          lfsr;
    int                   checks;
    int                   errors;

    tb_clock u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exu dut (
        .clk                (clk),
        .rst_n_i            (rst_n),
        .flush_i            (flush),
        .req_alu_i          (req_alu),
        .req_alu_data_i     (alu_data),
        .alu_wb_ready_i     (alu_ready),
        .req_bjp_i          (req_bjp),
        .req_bjp_data_i     (bjp_data),
        .int_jump_i         (int_jump),
        .int_addr_i         (int_addr),
        .mret_i             (mret),
        .req_csr_i          (req_csr),
        .req_csr_data_i     (csr_data),
        .csr_wb_ready_i     (csr_ready),
        .alu_wb_o           (alu_wb),
        .alu_stall_o        (alu_stall),
        .csr_wb_o           (csr_wb),
        .csr_stall_o        (csr_stall),
        .jump_flag_o        (jump_flag),
        .jump_addr_o        (jump_addr),
        .misaligned_fetch_o (misaligned)
    );

    // 16-bit Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input alu_req_t r);
        logic [63:0] ext;
        ext = {{32{r.op1[31]}}, r.op1} >> r.op2[4:0];
        case (r.op)
            alu_add:  return r.op1 + r.op2;
            alu_sub:  return r.op1 + ~r.op2 + 32'd1;
            alu_sll:  return r.op1 << r.op2[4:0];
            alu_slt:  return {31'd0, (r.op1 ^ 32'h8000_0000) < (r.op2 ^ 32'h8000_0000)};
            alu_sltu: return {31'd0, r.op1 < r.op2};
            alu_xor:  return r.op1 ^ r.op2;
            alu_srl:  return r.op1 >> r.op2[4:0];
            alu_sra:  return ext[31:0];
            alu_or:   return r.op1 | r.op2;
            alu_and:  return r.op1 & r.op2;
            default:  return '0;
        endcase
    endfunction

    // {jump flag, misaligned fetch, jump address}
    function automatic logic [33:0] jump_ref(input logic req, input bru_req_t r,
            input logic irq, input logic [31:0] irq_addr, input logic ret,
            input logic [31:0] mepc);
        logic        lt;
        logic        taken;
        logic [31:0] tgt;
        lt = (r.op1 ^ 32'h8000_0000) < (r.op2 ^ 32'h8000_0000);
        case (r.op)
            bru_beq:  taken = r.op1 == r.op2;
            bru_bne:  taken = r.op1 != r.op2;
            bru_blt:  taken = lt;
            bru_bltu: taken = r.op1 < r.op2;
            bru_bge:  taken = !lt;
            bru_bgeu: taken = !(r.op1 < r.op2);
            default:  taken = 1'b1;
        endcase
        taken = taken & req;
        tgt = r.jump_op1 + r.jump_op2;
        if (r.op == bru_jalr) tgt[0] = 1'b0;
        if (irq) return {2'b10, irq_addr};
        if (ret) return {2'b10, mepc};
        return {taken, taken & tgt[1], tgt};
    endfunction

    function automatic logic [31:0] csr_ref(input csr_op_e op, input logic [31:0] old,
            input logic [31:0] operand);
        case (op)
            csr_rw:  return operand;
            csr_rs:  return old | operand;
            csr_rc:  return old & ~operand;
            default: return old;
        endcase
    endfunction

    // unimplemented CSRs read zero
    function automatic logic [31:0] csr_read(input logic [`EXU_CSR_ADDR_W-1:0] addr);
        return csr_model.exists(addr) ? csr_model[addr] : '0;
    endfunction

    function automatic csr_req_t csr_req(input csr_op_e op, input logic [11:0] addr,
            input logic [31:0] operand, input logic [2:0] id);
        csr_req_t r;
        r.op        = op;
        r.addr      = addr;
        r.operand   = operand;
        r.rd        = {2'b01, id};
        r.csr_we    = 1'b1;
        r.reg_we    = 1'b1;
        r.commit_id = id;
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic verify_wb(input string name, input wb_t got, input wb_t exp,
            input logic valid);
        compare_value({name, ".we"}, got.we, exp.we & valid);
        if (valid) begin
            compare_value({name, ".wdata"}, got.wdata, exp.wdata);
            compare_value({name, ".waddr"}, got.waddr, exp.waddr);
            compare_value({name, ".commit_id"}, got.commit_id, exp.commit_id);
        end
    endtask

    // check what is visible now, then advance the model by this edge
    always @(posedge clk) begin
        logic [33:0] jref;
        if (!rst_n) begin
            alu_valid = 1'b0;
            csr_valid = 1'b0;
        end else begin
            verify_wb("alu_wb_o", alu_wb, alu_exp, alu_valid);
            verify_wb("csr_wb_o", csr_wb, csr_exp, csr_valid);
            compare_value("alu_stall_o", alu_stall, alu_valid & ~alu_ready);
            compare_value("csr_stall_o", csr_stall, csr_valid & ~csr_ready);
            jref = jump_ref(req_bjp, bjp_data, int_jump, int_addr, mret,
                            csr_read(`EXU_CSR_MEPC));
            compare_value("jump_flag_o", jump_flag, jref[33]);
            compare_value("misaligned_fetch_o", misaligned, jref[32]);
            if (jref[33]) begin
                compare_value("jump_addr_o", jump_addr, jref[31:0]);
            end
            if (flush) begin
                alu_valid = 1'b0;
                csr_valid = 1'b0;
            end else begin
                if (req_alu) begin
                    alu_valid = 1'b1;
                    alu_exp.wdata     = alu_ref(alu_data);
                    alu_exp.waddr     = alu_data.rd;
                    alu_exp.we        = alu_data.reg_we;
                    alu_exp.commit_id = alu_data.commit_id;
                end else if (alu_ready) begin
                    alu_valid = 1'b0;
                end
                if (req_csr) begin
                    csr_valid = 1'b1;
                    csr_exp.wdata     = csr_read(csr_data.addr);
                    csr_exp.waddr     = csr_data.rd;
                    csr_exp.we        = csr_data.reg_we;
                    csr_exp.commit_id = csr_data.commit_id;
                    if (csr_data.csr_we && csr_model.exists(csr_data.addr)) begin
                        csr_model[csr_data.addr] = csr_ref(csr_data.op, csr_exp.wdata,
                                                           csr_data.operand);
                    end
                end else if (csr_ready) begin
                    csr_valid = 1'b0;
                end
            end
        end
    end

    initial begin
        repeat (num_tests * 20) @(posedge clk);
        $display("watchdog expired before the stimulus finished");
        $display("Test failed");
        $finish;
    end

    initial begin
        flush     = 1'b0;
        req_alu   = 1'b0;
        alu_data  = '0;
        alu_ready = 1'b1;
        req_bjp   = 1'b0;
        bjp_data  = '0;
        int_jump  = 1'b0;
        int_addr  = '0;
        mret      = 1'b0;
        req_csr   = 1'b0;
        csr_data  = '0;
        csr_ready = 1'b1;
        checks    = 0;
        errors    = 0;
        lfsr      = 16'd49989;
        csr_model[`EXU_CSR_MSTATUS]  = '0;
        csr_model[`EXU_CSR_MTVEC]    = '0;
        csr_model[`EXU_CSR_MSCRATCH] = '0;
        csr_model[`EXU_CSR_MEPC]     = '0;
        csr_model[`EXU_CSR_MCAUSE]   = '0;
        @(posedge rst_n);
        @(negedge clk);

        // back-to-back ALU requests
        repeat (n_alu) begin
            req_alu            = 1'b1;
            alu_data.op        = alu_op_e'(4'(rand_bits(4) % 10));
            alu_data.op1       = rand_bits(32);
            alu_data.op2       = rand_bits(32);
            alu_data.rd        = 5'(rand_bits(5));
            alu_data.reg_we    = 1'(rand_bits(1));
            alu_data.commit_id = 3'(rand_bits(3));
            @(negedge clk);
        end
        req_alu = 1'b0;

        // ALU and CSR results held under back-pressure
        req_alu  = 1'b1;
        alu_data.reg_we = 1'b1;
        req_csr  = 1'b1;
        csr_data = csr_req(csr_rw, `EXU_CSR_MSCRATCH, 32'hA5A5_0001, 3'd1);
        @(negedge clk);
        req_alu   = 1'b0;
        req_csr   = 1'b0;
        alu_ready = 1'b0;
        csr_ready = 1'b0;
        repeat (5) @(negedge clk);
        alu_ready = 1'b1;
        csr_ready = 1'b1;
        @(negedge clk);

        // flush drops a held result
        req_alu = 1'b1;
        @(negedge clk);
        req_alu   = 1'b0;
        alu_ready = 1'b0;
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush     = 1'b0;
        alu_ready = 1'b1;
        @(negedge clk);

        // random branches with equal operands about half the time
        repeat (n_bru) begin
            req_bjp           = 1'b1;
            bjp_data.op       = bru_op_e'(3'(rand_bits(3)));
            bjp_data.op1      = rand_bits(32);
            bjp_data.op2      = rand_bits(1) ? bjp_data.op1 : rand_bits(32);
            bjp_data.jump_op1 = rand_bits(32);
            bjp_data.jump_op2 = rand_bits(4);
            @(negedge clk);
        end
        req_bjp = 1'b0;

        // read-modify-write on mscratch, then an unknown CSR, then mepc
        req_csr  = 1'b1;
        csr_data = csr_req(csr_rw, `EXU_CSR_MSCRATCH, 32'h1234_5678, 3'd2);
        @(negedge clk);
        csr_data = csr_req(csr_rs, `EXU_CSR_MSCRATCH, 32'h0000_00F0, 3'd3);
        @(negedge clk);
        csr_data = csr_req(csr_rc, `EXU_CSR_MSCRATCH, 32'h1000_0008, 3'd4);
        @(negedge clk);
        csr_data = csr_req(csr_rw, 12'h7C0, 32'hDEAD_BEEF, 3'd5);
        @(negedge clk);
        csr_data = csr_req(csr_rs, 12'h7C0, 32'h0, 3'd6);
        @(negedge clk);
        csr_data = csr_req(csr_rw, `EXU_CSR_MEPC, 32'h0000_2468, 3'd7);
        @(negedge clk);
        req_csr = 1'b0;
        @(negedge clk);

        // mret alone, then interrupt over mret, then interrupt over a branch
        mret = 1'b1;
        @(negedge clk);
        int_jump = 1'b1;
        int_addr = 32'h0000_0800;
        @(negedge clk);
        mret        = 1'b0;
        req_bjp     = 1'b1;
        bjp_data.op = bru_jal;
        @(negedge clk);
        int_jump = 1'b0;
        req_bjp  = 1'b0;
        repeat (2) @(negedge clk);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_csr_unit.sv
hdl/exu_csr_file.sv
hdl/exu.sv
testbench/tb_clock.sv
testbench/tb_exu.sv
